// ==== source/ccx_cfg_pkg.sv ====
// Crossbar sizing shared by all CPX blocks, referenced by scoped names
`default_nettype none

package ccx_cfg_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Fabric dimensions
   ////////////////////////////////////////////////////////////////////////////

   // Cache-bank sources feeding the return path
   localparam int NUM_SRC = 4;
   // Core destinations
   localparam int NUM_DEST = 2;
   // Entries per source queue, also the starting credit count
   localparam int QUEUE_DEPTH = 2;

   // Index types
   typedef logic [$clog2(NUM_SRC)-1:0]  src_id_t;
   typedef logic [$clog2(NUM_DEST)-1:0] dest_id_t;

   // One bit per source, used for request, win and grant vectors
   typedef logic [NUM_SRC-1:0] src_mask_t;

   // Queue pointer and occupancy
   typedef logic [$clog2(QUEUE_DEPTH)-1:0]   q_ptr_t;
   typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] q_cnt_t;

endpackage

`default_nettype wire

// ==== source/cpx_pkg.sv ====
// CPX return packet format, used by every block that carries a packet
`default_nettype none

package cpx_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Field widths
   ////////////////////////////////////////////////////////////////////////////

   // Return data word
   localparam int PAYLOAD_W = 64;

   typedef logic [PAYLOAD_W-1:0] payload_t;

   ////////////////////////////////////////////////////////////////////////////
   // Return types
   ////////////////////////////////////////////////////////////////////////////

   // Encodings follow the usual CPX return-type field
   typedef enum logic [3:0] {
      RTYPE_LOAD_RET = 4'b0000,
      RTYPE_INV      = 4'b0011,
      RTYPE_ST_ACK   = 4'b0100,
      RTYPE_INT_RET  = 4'b0111,
      RTYPE_ERR_RET  = 4'b1100
   } cpx_rtype_e;

   ////////////////////////////////////////////////////////////////////////////
   // Packets
   ////////////////////////////////////////////////////////////////////////////

   // Packet as delivered to a core, rtype in the top bits
   typedef struct packed {
      cpx_rtype_e           rtype;
      ccx_cfg_pkg::src_id_t src;
      payload_t             payload;
   } cpx_pkt_t;

   // What a source pushes: target core plus packet
   typedef struct packed {
      ccx_cfg_pkg::dest_id_t dest;
      cpx_pkt_t              pkt;
   } cpx_req_t;

   // Width of the core-facing bus
   localparam int CPX_WIDTH = $bits(cpx_pkt_t);

endpackage

`default_nettype wire

// ==== source/cpx_src_queue.sv ====
// Per-source two-entry request queue, pushed by strobe and popped by any arbiter win
`timescale 1ns/1ps
`default_nettype none

module cpx_src_queue (
   input  wire logic                rclk,
   input  wire logic                reset,
   input  wire logic                push,
   input  wire cpx_pkg::cpx_req_t   push_req,
   input  wire logic                pop,
   output logic                     head_vld,
   output cpx_pkg::cpx_req_t        head
);

   // Entry storage for whole requests
   cpx_pkg::cpx_req_t mem [ccx_cfg_pkg::QUEUE_DEPTH];

   ccx_cfg_pkg::q_ptr_t wr_ptr;
   ccx_cfg_pkg::q_ptr_t rd_ptr;
   ccx_cfg_pkg::q_cnt_t count;

   // Circular pointer step
   function automatic ccx_cfg_pkg::q_ptr_t next_ptr(input ccx_cfg_pkg::q_ptr_t p);
      if (p == ccx_cfg_pkg::q_ptr_t'(ccx_cfg_pkg::QUEUE_DEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // Simultaneous push and pop leave the count unchanged
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Write port
   always_ff @(posedge rclk) begin
      if (push) begin
         mem[wr_ptr] <= push_req;
      end
   end

   // Head is visible the cycle after the push
   assign head_vld = (count != '0);
   assign head     = mem[rd_ptr];

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Source credit accounting must keep the queue from overflowing
   a_no_push_full: assert property (@(posedge rclk) disable iff (reset)
      push |-> (count < ccx_cfg_pkg::QUEUE_DEPTH));

   // Arbiters only pick valid heads
   a_no_pop_empty: assert property (@(posedge rclk) disable iff (reset)
      pop |-> head_vld);

endmodule

`default_nettype wire

// ==== source/cpx_arbiter.sv ====
// Round-robin arbiter for one core destination, with a registered grant back to the sources
`timescale 1ns/1ps
`default_nettype none

module cpx_arbiter (
   input  wire logic                    rclk,
   input  wire logic                    reset,
   input  wire ccx_cfg_pkg::src_mask_t  req,
   output ccx_cfg_pkg::src_mask_t       win,
   output ccx_cfg_pkg::src_mask_t       grant
);

   // Highest-priority source for the next search
   ccx_cfg_pkg::src_id_t ptr;
   // Index of this cycle's winner
   ccx_cfg_pkg::src_id_t win_idx;

   ////////////////////////////////////////////////////////////////////////////
   // Round-robin search
   ////////////////////////////////////////////////////////////////////////////

   // Scan from the pointer, wrapping, and take the first requester
   always_comb begin : rr_search
      int   idx;
      logic found;
      win     = '0;
      win_idx = ptr;
      found   = 1'b0;
      for (int k = 0; k < ccx_cfg_pkg::NUM_SRC; k++) begin
         idx = (int'(ptr) + k) % ccx_cfg_pkg::NUM_SRC;
         if (!found && req[idx]) begin
            found        = 1'b1;
            win[idx]     = 1'b1;
            win_idx      = ccx_cfg_pkg::src_id_t'(idx);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Pointer and grant
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (reset) begin
         ptr   <= '0;
         grant <= '0;
      end else begin
         // Move one past the winner
         if (|win) begin
            ptr <= ccx_cfg_pkg::src_id_t'((int'(win_idx) + 1) % ccx_cfg_pkg::NUM_SRC);
         end
         // Grant returns a credit one cycle after the pop
         grant <= win;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // At most one source dequeued per destination and cycle
   a_win_onehot: assert property (@(posedge rclk) disable iff (reset)
      $onehot0(win));

   // Never pop a queue that is not requesting
   a_win_in_req: assert property (@(posedge rclk) disable iff (reset)
      (win & ~req) == '0);

endmodule

`default_nettype wire

// ==== source/cpx_dest_mux.sv ====
// Winner select for one destination, registered active-low onto the cx stage
`timescale 1ns/1ps
`default_nettype none

module cpx_dest_mux (
   input  wire logic                    rclk,
   input  wire logic                    reset,
   input  wire ccx_cfg_pkg::src_mask_t  win,
   input  wire cpx_pkg::cpx_pkt_t       cand [ccx_cfg_pkg::NUM_SRC],
   output cpx_pkg::cpx_pkt_t            data_cx_l,
   output logic                         rdy_cx
);

   // Selected packet, true polarity
   cpx_pkg::cpx_pkt_t sel;

   ////////////////////////////////////////////////////////////////////////////
   // One-hot select
   ////////////////////////////////////////////////////////////////////////////

   // Win is one-hot, so an AND-OR tree is enough
   always_comb begin
      sel = '0;
      for (int i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin
         sel = cpx_pkg::cpx_pkt_t'(sel | ({cpx_pkg::CPX_WIDTH{win[i]}} & cand[i]));
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // cx stage register
   ////////////////////////////////////////////////////////////////////////////

   // Long wires carry data inverted; idle level is all ones
   always_ff @(posedge rclk) begin
      if (reset) begin
         data_cx_l <= cpx_pkg::cpx_pkt_t'({cpx_pkg::CPX_WIDTH{1'b1}});
         rdy_cx    <= 1'b0;
      end else begin
         rdy_cx <= |win;
         // Hold last packet when nothing wins
         if (|win) begin
            data_cx_l <= cpx_pkg::cpx_pkt_t'(~sel);
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/cpx_datacx2_ff.sv ====
// cx2 staging of one core's return bus, restoring true data polarity
`timescale 1ns/1ps
`default_nettype none

module cpx_datacx2_ff (
   input  wire logic               rclk,
   input  wire logic               reset,
   input  wire cpx_pkg::cpx_pkt_t  data_cx_l,
   input  wire logic               rdy_cx,
   output cpx_pkg::cpx_pkt_t       data_cx2,
   output logic                    rdy_cx2
);

   // Still active low here
   cpx_pkg::cpx_pkt_t data_cx2_l;

   ////////////////////////////////////////////////////////////////////////////
   // Staging flops
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (reset) begin
         // All ones reads back as a zero packet
         data_cx2_l <= cpx_pkg::cpx_pkt_t'({cpx_pkg::CPX_WIDTH{1'b1}});
         rdy_cx2    <= 1'b0;
      end else begin
         data_cx2_l <= data_cx_l;
         rdy_cx2    <= rdy_cx;
      end
   end

   // Back to true polarity for the core
   assign data_cx2 = cpx_pkg::cpx_pkt_t'(~data_cx2_l);

endmodule

`default_nettype wire

// ==== source/cpx_xbar_top.sv ====
// CPX return crossbar slice, four cache-bank sources to two cores
`timescale 1ns/1ps
`default_nettype none

module cpx_xbar_top (
   input  wire logic                    rclk,
   input  wire logic                    reset,
   input  wire ccx_cfg_pkg::src_mask_t  src_req_vld,
   input  wire cpx_pkg::cpx_req_t       src_req [ccx_cfg_pkg::NUM_SRC],
   output ccx_cfg_pkg::src_mask_t       src_grant,
   output cpx_pkg::cpx_pkt_t            dest_data [ccx_cfg_pkg::NUM_DEST],
   output logic [ccx_cfg_pkg::NUM_DEST-1:0] dest_rdy
);

   // Queue heads
   logic                   head_vld [ccx_cfg_pkg::NUM_SRC];
   cpx_pkg::cpx_req_t      head     [ccx_cfg_pkg::NUM_SRC];
   cpx_pkg::cpx_pkt_t      cand     [ccx_cfg_pkg::NUM_SRC];
   ccx_cfg_pkg::src_mask_t pop;

   // Per-destination arbitration
   ccx_cfg_pkg::src_mask_t req   [ccx_cfg_pkg::NUM_DEST];
   ccx_cfg_pkg::src_mask_t win   [ccx_cfg_pkg::NUM_DEST];
   ccx_cfg_pkg::src_mask_t grant [ccx_cfg_pkg::NUM_DEST];

   // cx stage, active-low data
   cpx_pkg::cpx_pkt_t      data_cx_l [ccx_cfg_pkg::NUM_DEST];
   logic                   rdy_cx    [ccx_cfg_pkg::NUM_DEST];

   ////////////////////////////////////////////////////////////////////////////
   // Input side
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin : g_src
      cpx_src_queue cpx_src_queue_inst (
         .rclk     (rclk),
         .reset    (reset),
         .push     (src_req_vld[i]),
         .push_req (src_req[i]),
         .pop      (pop[i]),
         .head_vld (head_vld[i]),
         .head     (head[i])
      );

      assign cand[i] = head[i].pkt;
   end

   // Pop on any win, grant on any registered win
   always_comb begin
      pop       = '0;
      src_grant = '0;
      for (int d = 0; d < ccx_cfg_pkg::NUM_DEST; d++) begin
         pop       = pop | win[d];
         src_grant = src_grant | grant[d];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Processing part and output side
   ////////////////////////////////////////////////////////////////////////////

   for (genvar d = 0; d < ccx_cfg_pkg::NUM_DEST; d++) begin : g_dest
      // Valid heads aimed at this core
      for (genvar i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin : g_req
         assign req[d][i] = head_vld[i] && (head[i].dest == ccx_cfg_pkg::dest_id_t'(d));
      end

      cpx_arbiter cpx_arbiter_inst (
         .rclk  (rclk),
         .reset (reset),
         .req   (req[d]),
         .win   (win[d]),
         .grant (grant[d])
      );

      cpx_dest_mux cpx_dest_mux_inst (
         .rclk      (rclk),
         .reset     (reset),
         .win       (win[d]),
         .cand      (cand),
         .data_cx_l (data_cx_l[d]),
         .rdy_cx    (rdy_cx[d])
      );

      cpx_datacx2_ff cpx_datacx2_ff_inst (
         .rclk      (rclk),
         .reset     (reset),
         .data_cx_l (data_cx_l[d]),
         .rdy_cx    (rdy_cx[d]),
         .data_cx2  (dest_data[d]),
         .rdy_cx2   (dest_rdy[d])
      );
   end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// Testbench clock and power-on reset source, instantiated once by the crossbar testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic rclk,
   output logic reset
);

   // 8 ns period
   initial begin
      rclk = 1'b0;
      forever #4 rclk = ~rclk;
   end

   // Reset held for 10 rising edges, released just after the last one
   initial begin
      reset = 1'b1;
      repeat (10) @(posedge rclk);
      #1 reset = 1'b0;
   end

endmodule

`default_nettype wire

// ==== sim/cpx_xbar_tb.sv ====
// Self-checking testbench for the CPX return crossbar, compiled as the simulation top
`timescale 1ns/1ps
`default_nettype none

module cpx_xbar_tb;

   logic                             rclk;
   logic                             reset;
   ccx_cfg_pkg::src_mask_t           src_req_vld;
   cpx_pkg::cpx_req_t                src_req   [ccx_cfg_pkg::NUM_SRC];
   ccx_cfg_pkg::src_mask_t           src_grant;
   cpx_pkg::cpx_pkt_t                dest_data [ccx_cfg_pkg::NUM_DEST];
   logic [ccx_cfg_pkg::NUM_DEST-1:0] dest_rdy;

   // Expected packets per source and destination in push order
   cpx_pkg::cpx_pkt_t model_q [ccx_cfg_pkg::NUM_SRC][ccx_cfg_pkg::NUM_DEST][$];
   // Packet due on each core at the next edge
   cpx_pkg::cpx_pkt_t exp_pkt [ccx_cfg_pkg::NUM_DEST];
   logic [ccx_cfg_pkg::NUM_DEST-1:0] exp_ok;
   int sent_cnt  [ccx_cfg_pkg::NUM_SRC];
   int grant_cnt [ccx_cfg_pkg::NUM_SRC];

   string test_name;
   int    err_cnt;
   int    err_before;
   int    tests_ok;
   int    tests_bad;
   logic  timed_out;
   // Test-specific check enables and their expected values
   logic  single_chk;
   logic  par_chk;
   logic  rr_chk;
   ccx_cfg_pkg::src_mask_t           exp_grant;
   logic [ccx_cfg_pkg::NUM_DEST-1:0] exp_rdy;
   ccx_cfg_pkg::src_id_t             rr_exp;
   logic [31:0] lfsr_state;

   // Return types drawn for generated packets
   cpx_pkg::cpx_rtype_e rtype_tbl [5] = '{cpx_pkg::RTYPE_LOAD_RET, cpx_pkg::RTYPE_ST_ACK,
      cpx_pkg::RTYPE_INV, cpx_pkg::RTYPE_INT_RET, cpx_pkg::RTYPE_ERR_RET};

   tb_clock_gen tb_clock_gen_inst (
      .rclk  (rclk),
      .reset (reset)
   );

   cpx_xbar_top cpx_xbar_top_inst (
      .rclk        (rclk),
      .reset       (reset),
      .src_req_vld (src_req_vld),
      .src_req     (src_req),
      .src_grant   (src_grant),
      .dest_data   (dest_data),
      .dest_rdy    (dest_rdy)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   // Galois LFSR stepped once per bit taken
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v          = {v[62:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      end
      return v;
   endfunction

   // Strobe one generated packet from source i toward core d
   task automatic push_pkt(input int i, input int d);
      cpx_pkg::cpx_pkt_t pkt;
      pkt.rtype       = rtype_tbl[rand_bits(3) % 5];
      pkt.src         = ccx_cfg_pkg::src_id_t'(i);
      pkt.payload     = rand_bits(cpx_pkg::PAYLOAD_W);
      src_req[i].dest = ccx_cfg_pkg::dest_id_t'(d);
      src_req[i].pkt  = pkt;
      src_req_vld[i]  = 1'b1;
      model_q[i][d].push_back(pkt);
      sent_cnt[i]++;
   endtask

   // Strobes last exactly one cycle
   task automatic next_cycle();
      @(posedge rclk);
      #1;
      src_req_vld = '0;
   endtask

   task automatic note_timeout(input string what);
      timed_out = 1'b1;
      err_cnt++;
      $display("Timeout in %s while waiting for %s", test_name, what);
   endtask

   function automatic logic fabric_idle();
      for (int i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin
         for (int d = 0; d < ccx_cfg_pkg::NUM_DEST; d++) begin
            if (model_q[i][d].size() != 0) begin
               return 1'b0;
            end
         end
      end
      return dest_rdy == '0;
   endfunction

   // Every expected packet delivered and both cores quiet
   task automatic drain(input int limit);
      int n;
      for (n = 0; n < limit; n++) begin
         @(posedge rclk);
         if (fabric_idle()) begin
            break;
         end
      end
      if (n == limit) begin
         note_timeout("all packets to come out");
      end
      #1;
   endtask

   task automatic begin_test(input string name);
      test_name  = name;
      err_before = err_cnt;
   endtask

   task automatic end_test();
      if (err_cnt == err_before) begin
         tests_ok++;
         $display("Test %s passed", test_name);
      end else begin
         tests_bad++;
         $display("Test %s failed with %0d errors", test_name, err_cnt - err_before);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic wait_reset();
      int n;
      for (n = 0; n < 40; n++) begin
         @(posedge rclk);
         if (!reset) begin
            break;
         end
      end
      if (n == 40) begin
         note_timeout("reset release");
      end
      #1;
   endtask

   // All four sources to core 0 in one cycle
   task automatic send_burst();
      for (int i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin
         push_pkt(i, 0);
      end
      next_cycle();
   endtask

   task automatic round_robin_bursts();
      begin_test("round_robin");
      // Pointer starts at source 0 after reset
      rr_exp = '0;
      rr_chk = 1'b1;
      send_burst();
      drain(40);
      // Lone win by source 1 leaves the pointer on source 2
      rr_chk = 1'b0;
      push_pkt(1, 0);
      next_cycle();
      drain(40);
      rr_exp = ccx_cfg_pkg::src_id_t'(2);
      rr_chk = 1'b1;
      send_burst();
      drain(40);
      rr_chk = 1'b0;
      end_test();
   endtask

   task automatic single_latency();
      begin_test("single_latency");
      exp_grant  = 4'b1000;
      exp_rdy    = 2'b10;
      single_chk = 1'b1;
      push_pkt(3, 1);
      next_cycle();
      drain(20);
      single_chk = 1'b0;
      end_test();
   endtask

   task automatic parallel_dests();
      begin_test("parallel_dest");
      par_chk = 1'b1;
      push_pkt(0, 0);
      push_pkt(2, 1);
      next_cycle();
      drain(20);
      par_chk = 1'b0;
      end_test();
   endtask

   // Random strobes, limited by the credits each source holds
   task automatic random_traffic();
      logic want;
      int   d;
      begin_test("random");
      for (int c = 0; c < 400; c++) begin
         for (int i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin
            want = 1'(rand_bits(1));
            d    = int'(rand_bits(1));
            if (want && (sent_cnt[i] - grant_cnt[i]) < ccx_cfg_pkg::QUEUE_DEPTH) begin
               push_pkt(i, d);
            end
         end
         next_cycle();
      end
      drain(200);
      for (int i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin
         assert (grant_cnt[i] == sent_cnt[i]) else begin
            err_cnt++;
            $display("CHECK FAILED %s grants of source %0d expected %0d actual %0d",
               test_name, i, sent_cnt[i], grant_cnt[i]);
         end
      end
      end_test();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Monitors
   ////////////////////////////////////////////////////////////////////////////

   // Credits come back on grant; the round-robin expectation steps per packet
   always @(posedge rclk) begin
      if (!reset) begin
         for (int i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin
            if (src_grant[i]) begin
               grant_cnt[i]++;
            end
         end
      end
      if (rr_chk && dest_rdy[0]) begin
         rr_exp <= rr_exp + 1'b1;
      end
   end

   // Picks the next expected packet mid-cycle, from the queue named by its source
   always @(negedge rclk) begin : scoreboard
      ccx_cfg_pkg::src_id_t s;
      for (int d = 0; d < ccx_cfg_pkg::NUM_DEST; d++) begin
         exp_ok[d] = 1'b0;
         if (dest_rdy[d] === 1'b1) begin
            s = dest_data[d].src;
            if (model_q[s][d].size() != 0) begin
               exp_pkt[d] = model_q[s][d].pop_front();
               exp_ok[d]  = 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   a_reset_quiet: assert property (@(posedge rclk) reset |=> (dest_rdy == '0 &&
      src_grant == '0 && dest_data[0] == '0 && dest_data[1] == '0)) else begin
      err_cnt++;
      $display("CHECK FAILED %s rdy grant data expected 0 actual %b %b %h %h", test_name,
         $sampled(dest_rdy), $sampled(src_grant), $sampled(dest_data[0]),
         $sampled(dest_data[1]));
   end

   for (genvar d = 0; d < ccx_cfg_pkg::NUM_DEST; d++) begin : g_sb
      a_sb_pending: assert property (@(posedge rclk) disable iff (reset)
         dest_rdy[d] |-> exp_ok[d]) else begin
         err_cnt++;
         $display("Core %0d got a packet in %s that no source sent", d, test_name);
      end
      a_sb_data: assert property (@(posedge rclk) disable iff (reset)
         dest_rdy[d] && exp_ok[d] |-> dest_data[d] == exp_pkt[d]) else begin
         err_cnt++;
         $display("CHECK FAILED %s core %0d expected %h actual %h", test_name, d,
            $sampled(exp_pkt[d]), $sampled(dest_data[d]));
      end
   end

   // Credit count stays within 0 to QUEUE_DEPTH
   for (genvar i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin : g_credit
      a_credit_range: assert property (@(posedge rclk) disable iff (reset)
         (sent_cnt[i] - grant_cnt[i]) inside {[0:ccx_cfg_pkg::QUEUE_DEPTH]}) else begin
         err_cnt++;
         $display("Credit count of source %0d left its legal range in %s", i, test_name);
      end
   end

   // Grant two cycles after the strobe cycle, ready one cycle later for one cycle
   a_lat_grant: assert property (@(posedge rclk) disable iff (reset)
      single_chk && src_req_vld != '0 |-> ##2 src_grant == exp_grant) else begin
      err_cnt++;
      $display("CHECK FAILED %s grant expected %b actual %b", test_name, exp_grant,
         $sampled(src_grant));
   end
   a_lat_rdy: assert property (@(posedge rclk) disable iff (reset)
      single_chk && src_req_vld != '0 |-> ##3 dest_rdy == exp_rdy ##1 dest_rdy == '0)
      else begin
      err_cnt++;
      $display("CHECK FAILED %s ready expected %b for one cycle actual %b", test_name,
         exp_rdy, $sampled(dest_rdy));
   end

   a_parallel: assert property (@(posedge rclk) disable iff (reset)
      par_chk && dest_rdy != '0 |-> dest_rdy == '1) else begin
      err_cnt++;
      $display("CHECK FAILED %s ready expected 11 actual %b", test_name, $sampled(dest_rdy));
   end

   a_rr_order: assert property (@(posedge rclk) disable iff (reset)
      rr_chk && dest_rdy[0] |-> dest_data[0].src == rr_exp) else begin
      err_cnt++;
      $display("CHECK FAILED %s source expected %0d actual %0d", test_name, $sampled(rr_exp),
         $sampled(dest_data[0].src));
   end
   a_rr_back_to_back: assert property (@(posedge rclk) disable iff (reset)
      rr_chk && $rose(dest_rdy[0]) |-> dest_rdy[0] [*4] ##1 !dest_rdy[0]) else begin
      err_cnt++;
      $display("Burst in %s did not come out on four consecutive cycles", test_name);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      src_req_vld = '0;
      for (int i = 0; i < ccx_cfg_pkg::NUM_SRC; i++) begin
         src_req[i]   = '0;
         sent_cnt[i]  = 0;
         grant_cnt[i] = 0;
      end
      exp_ok     = '0;
      err_cnt    = 0;
      tests_ok   = 0;
      tests_bad  = 0;
      timed_out  = 1'b0;
      single_chk = 1'b0;
      par_chk    = 1'b0;
      rr_chk     = 1'b0;
      exp_grant  = '0;
      exp_rdy    = '0;
      rr_exp     = '0;
      lfsr_state = 32'h41fd_3466;
      begin_test("reset");
      wait_reset();
      end_test();
      round_robin_bursts();
      single_latency();
      parallel_dests();
      random_traffic();
      $display("Tests passed %0d, tests failed %0d, failed checks %0d", tests_ok, tests_bad,
         err_cnt);
      if (err_cnt == 0 && !timed_out) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/ccx_cfg_pkg.sv
source/cpx_pkg.sv
source/cpx_src_queue.sv
source/cpx_arbiter.sv
source/cpx_dest_mux.sv
source/cpx_datacx2_ff.sv
source/cpx_xbar_top.sv
sim/tb_clock_gen.sv
sim/cpx_xbar_tb.sv

// ==== Bender.yml ====
package:
  name: cpx_xbar

sources:
  # Packages first, then the RTL in dependency order
  - files:
      - source/ccx_cfg_pkg.sv
      - source/cpx_pkg.sv
      - source/cpx_src_queue.sv
      - source/cpx_arbiter.sv
      - source/cpx_dest_mux.sv
      - source/cpx_datacx2_ff.sv
      - source/cpx_xbar_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/cpx_xbar_tb.sv
